/* rtl/fpnc_pkg.sv */
/*
  Shared definitions for the binary32 non-computational unit
  Format is fixed to IEEE 754 single precision
  Only the NV status flag is ever raised by this unit
*/
package fpnc_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned FP_W  = 32;
  localparam int unsigned EXP_W = 8;
  localparam int unsigned MAN_W = 23;
  // Tag travels untouched alongside each item
  localparam int unsigned TAG_W = 4;

  // Canonical quiet NaN, positive with only the top mantissa bit set
  localparam logic [FP_W-1:0] QNAN_BITS = 32'h7fc0_0000;

  // Binary32 layout
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exponent;
    logic [MAN_W-1:0] mantissa;
  } fp_t;

  // Operation groups
  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } op_e;

  // Variant within a group
  // MODE_0 SGNJ / MIN / LE, MODE_1 SGNJN / MAX / LT
  // MODE_2 SGNJX / EQ, MODE_3 sign injection passthrough
  typedef enum logic [1:0] {
    MODE_0 = 2'd0,
    MODE_1 = 2'd1,
    MODE_2 = 2'd2,
    MODE_3 = 2'd3
  } mode_e;

  // IEEE exception flags
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // One-hot classification result, bit 0 upward
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // Decoded operand properties
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // Stage word widths
  // Input  = operand A, operand B, op, mode, op_mod, tag
  // Output = result, status, class mask, is_class, tag
  localparam int unsigned IN_W  = 2 * FP_W + 2 + 2 + 1 + TAG_W;
  localparam int unsigned OUT_W = FP_W + 5 + 10 + 1 + TAG_W;

endpackage

/* rtl/fpnc_classifier.sv */
/*
  Purely combinational binary32 operand decoder
  sNaN and qNaN are told apart by the top mantissa bit only
*/
`timescale 1ns/1ps

module fpnc_classifier
  import fpnc_pkg::*;
(
  input  fp_t      operand_i,
  output fp_info_t info_o
);

  // --------------------------------------------------------------------------
  // Field decode
  // --------------------------------------------------------------------------
  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  // Exponent all zeros marks zero or subnormal
  assign exp_zero = (operand_i.exponent == '0);
  // Exponent all ones marks infinity or NaN
  assign exp_ones = (operand_i.exponent == '1);
  assign man_zero = (operand_i.mantissa == '0);

  // --------------------------------------------------------------------------
  // Class flags
  // --------------------------------------------------------------------------
  always_comb begin
    info_o = '0;
    // Finite non-zero with implicit leading one
    info_o.is_normal    = ~exp_zero & ~exp_ones;
    // Denormalized, no implicit one
    info_o.is_subnormal = exp_zero & ~man_zero;
    // Signed zero
    info_o.is_zero      = exp_zero & man_zero;
    info_o.is_inf       = exp_ones & man_zero;
    info_o.is_nan       = exp_ones & ~man_zero;
    // Quiet bit clear means signalling
    info_o.is_signalling = info_o.is_nan & ~operand_i.mantissa[MAN_W-1];
    info_o.is_quiet      = info_o.is_nan &  operand_i.mantissa[MAN_W-1];
  end

endmodule

/* rtl/fpnc_pipe_stage.sv */
/*
  Single elastic register stage with valid/ready handshake
  Ready is combinational from ready_i, so chained stages form one ready path
  Flush drops the held item and blocks the one presented on the same edge
*/
`timescale 1ns/1ps

module fpnc_pipe_stage #(
  parameter int unsigned DATA_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              flush_i,
  // Upstream side
  input  logic              valid_i,
  output logic              ready_o,
  input  logic [DATA_W-1:0] data_i,
  // Downstream side
  output logic              valid_o,
  input  logic              ready_i,
  output logic [DATA_W-1:0] data_o
);

  logic              valid_q;
  logic [DATA_W-1:0] data_q;

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  // --------------------------------------------------------------------------
  // Valid flag
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Synchronous clear wins over any load
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // --------------------------------------------------------------------------
  // Payload register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_q <= '0;
    end else if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* rtl/fpnc_ops.sv */
/*
  Combinational binary32 sign injection, min/max, compare and classify
  Comparison boolean sits in result bit 0, op_mod_i inverts it
  Unused mode encodings return a zero result with no flags
*/
`timescale 1ns/1ps

module fpnc_ops
  import fpnc_pkg::*;
(
  input  fp_t        operand_a_i,
  input  fp_t        operand_b_i,
  input  op_e        op_i,
  input  mode_e      mode_i,
  input  logic       op_mod_i,
  output fp_t        result_o,
  output status_t    status_o,
  output classmask_e class_mask_o,
  output logic       is_class_o
);

  // --------------------------------------------------------------------------
  // Operand decode
  // --------------------------------------------------------------------------
  fp_info_t info_a;
  fp_info_t info_b;

  fpnc_classifier u_class_a (
    .operand_i (operand_a_i),
    .info_o    (info_a)
  );

  fpnc_classifier u_class_b (
    .operand_i (operand_b_i),
    .info_o    (info_b)
  );

  // Shared special-case terms
  logic any_nan;
  logic sig_nan;
  logic equal;
  logic a_smaller;

  assign any_nan = info_a.is_nan | info_b.is_nan;
  assign sig_nan = info_a.is_signalling | info_b.is_signalling;
  // +0 and -0 compare equal
  assign equal   = (operand_a_i == operand_b_i) | (info_a.is_zero & info_b.is_zero);
  // Magnitude compare on raw bits, order flips once a sign is set
  assign a_smaller = (operand_a_i < operand_b_i) ^ (operand_a_i.sign | operand_b_i.sign);

  // --------------------------------------------------------------------------
  // Sign injection
  // --------------------------------------------------------------------------
  fp_t sgnj_result;

  always_comb begin
    sgnj_result = operand_a_i;
    unique case (mode_i)
      MODE_0:  sgnj_result.sign = operand_b_i.sign;
      MODE_1:  sgnj_result.sign = ~operand_b_i.sign;
      MODE_2:  sgnj_result.sign = operand_a_i.sign ^ operand_b_i.sign;
      // Passthrough keeps operand A as is
      default: sgnj_result = operand_a_i;
    endcase
  end

  // --------------------------------------------------------------------------
  // Minimum / maximum
  // --------------------------------------------------------------------------
  fp_t     minmax_result;
  status_t minmax_status;

  always_comb begin
    minmax_result = '0;
    minmax_status = '0;
    if (mode_i == MODE_0 || mode_i == MODE_1) begin
      // Quiet compare, only sNaN is invalid
      minmax_status.NV = sig_nan;
      if (info_a.is_nan && info_b.is_nan) begin
        minmax_result = QNAN_BITS;
      end else if (info_a.is_nan) begin
        minmax_result = operand_b_i;
      end else if (info_b.is_nan) begin
        minmax_result = operand_a_i;
      end else if (mode_i == MODE_0) begin
        minmax_result = a_smaller ? operand_a_i : operand_b_i;
      end else begin
        minmax_result = a_smaller ? operand_b_i : operand_a_i;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Comparisons
  // --------------------------------------------------------------------------
  fp_t     cmp_result;
  status_t cmp_status;

  always_comb begin
    cmp_result = '0;
    cmp_status = '0;
    unique case (mode_i)
      MODE_0: begin
        // LE is a signalling compare, any NaN is invalid
        cmp_status.NV = any_nan;
        if (!any_nan) cmp_result[0] = (a_smaller | equal) ^ op_mod_i;
      end
      MODE_1: begin
        cmp_status.NV = any_nan;
        if (!any_nan) cmp_result[0] = (a_smaller & ~equal) ^ op_mod_i;
      end
      MODE_2: begin
        // EQ is quiet, NaN is simply unequal
        cmp_status.NV = sig_nan;
        cmp_result[0] = any_nan ? op_mod_i : (equal ^ op_mod_i);
      end
      default: begin
        cmp_result = '0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Classification of operand A
  // --------------------------------------------------------------------------
  always_comb begin
    if (info_a.is_normal) begin
      class_mask_o = operand_a_i.sign ? NEGNORM : POSNORM;
    end else if (info_a.is_subnormal) begin
      class_mask_o = operand_a_i.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a.is_zero) begin
      class_mask_o = operand_a_i.sign ? NEGZERO : POSZERO;
    end else if (info_a.is_inf) begin
      class_mask_o = operand_a_i.sign ? NEGINF : POSINF;
    end else begin
      // Only NaN is left here
      class_mask_o = info_a.is_signalling ? SNAN : QNAN;
    end
  end

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  always_comb begin
    result_o = '0;
    status_o = '0;
    unique case (op_i)
      OP_SGNJ: begin
        // Sign injection never raises flags
        result_o = sgnj_result;
      end
      OP_MINMAX: begin
        result_o = minmax_result;
        status_o = minmax_status;
      end
      OP_CMP: begin
        result_o = cmp_result;
        status_o = cmp_status;
      end
      default: begin
        // Classify answers on the mask port only
        result_o = '0;
      end
    endcase
  end

  assign is_class_o = (op_i == OP_CLASSIFY);

endmodule

/* rtl/fpnc_top.sv */
/*
  Two-stage pipelined binary32 non-computational unit
  Latency two cycles, throughput one item per cycle, holds two items
  Payload must stay stable while in_valid_i waits for in_ready_o
*/
`timescale 1ns/1ps

module fpnc_top
  import fpnc_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flush_i,
  // Request payload
  input  fp_t              operand_a_i,
  input  fp_t              operand_b_i,
  input  op_e              op_i,
  input  mode_e            mode_i,
  input  logic             op_mod_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  // Response payload
  output fp_t              result_o,
  output status_t          status_o,
  output classmask_e       class_mask_o,
  output logic             is_class_o,
  output logic [TAG_W-1:0] tag_o,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic             busy_o
);

  // --------------------------------------------------------------------------
  // Input stage
  // --------------------------------------------------------------------------
  logic [IN_W-1:0]  in_word;
  logic [IN_W-1:0]  in_q;
  logic             in_valid_q;
  logic             mid_ready;
  fp_t              op_a_q;
  fp_t              op_b_q;
  logic [1:0]       op_q;
  logic [1:0]       mode_q;
  logic             op_mod_q;
  logic [TAG_W-1:0] tag_q;

  assign in_word = {operand_a_i, operand_b_i, op_i, mode_i, op_mod_i, tag_i};

  fpnc_pipe_stage #(.DATA_W(IN_W)) u_in_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .valid_i  (in_valid_i),
    .ready_o  (in_ready_o),
    .data_i   (in_word),
    .valid_o  (in_valid_q),
    .ready_i  (mid_ready),
    .data_o   (in_q)
  );

  assign {op_a_q, op_b_q, op_q, mode_q, op_mod_q, tag_q} = in_q;

  // --------------------------------------------------------------------------
  // Operation logic and output stage
  // --------------------------------------------------------------------------
  fp_t              ops_result;
  status_t          ops_status;
  classmask_e       ops_class;
  logic             ops_is_class;
  logic [OUT_W-1:0] out_q;
  logic             out_valid_q;
  logic [9:0]       class_bits;

  fpnc_ops u_ops (
    .operand_a_i  (op_a_q),
    .operand_b_i  (op_b_q),
    .op_i         (op_e'(op_q)),
    .mode_i       (mode_e'(mode_q)),
    .op_mod_i     (op_mod_q),
    .result_o     (ops_result),
    .status_o     (ops_status),
    .class_mask_o (ops_class),
    .is_class_o   (ops_is_class)
  );

  // Tag bypasses the operation logic
  fpnc_pipe_stage #(.DATA_W(OUT_W)) u_out_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .valid_i  (in_valid_q),
    .ready_o  (mid_ready),
    .data_i   ({ops_result, ops_status, ops_class, ops_is_class, tag_q}),
    .valid_o  (out_valid_q),
    .ready_i  (out_ready_i),
    .data_o   (out_q)
  );

  assign {result_o, status_o, class_bits, is_class_o, tag_o} = out_q;
  assign class_mask_o = classmask_e'(class_bits);
  assign out_valid_o  = out_valid_q;
  // Anything held in either stage counts as in flight
  assign busy_o       = in_valid_q | out_valid_q;

endmodule

/* dv/fpnc_tb.sv */
/*
  Random testbench for the binary32 non-computational pipeline
  Expected values come from a behavioral model kept in a FIFO queue
  Handshakes are sampled on the falling edge, inputs change 1 ns after rising
*/
`timescale 1ns/1ps

module fpnc_tb
  import fpnc_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int N_TXN      = 400;
  // Generous bound, about 20 cycles per item
  localparam int TIMEOUT_NS = N_TXN * 20 * CLK_PERIOD;

  typedef struct packed {
    fp_t              result;
    status_t          status;
    logic [9:0]       mask;
    logic             is_class;
    logic [TAG_W-1:0] tag;
  } expect_t;

  logic clk_i;
  logic arst_n_i;
  logic flush_i;
  fp_t operand_a_i;
  fp_t operand_b_i;
  op_e op_i;
  mode_e mode_i;
  logic op_mod_i;
  logic [TAG_W-1:0] tag_i;
  logic in_valid_i;
  logic in_ready_o;
  fp_t result_o;
  status_t status_o;
  classmask_e class_mask_o;
  logic is_class_o;
  logic [TAG_W-1:0] tag_o;
  logic out_valid_o;
  logic out_ready_i;
  logic busy_o;

  expect_t exp_q[$];
  int errors = 0;
  int checked = 0;
  int accepted = 0;
  logic in_fire = 1'b0;
  logic busy_check = 1'b0;
  logic reset_checked = 1'b0;

  fpnc_top fpnc_top_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .op_i         (op_i),
    .mode_i       (mode_i),
    .op_mod_i     (op_mod_i),
    .tag_i        (tag_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .result_o     (result_o),
    .status_o     (status_o),
    .class_mask_o (class_mask_o),
    .is_class_o   (is_class_o),
    .tag_o        (tag_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .busy_o       (busy_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic nan_of(fp_t x);
    return (x.exponent == 8'hff) && (x.mantissa != 23'd0);
  endfunction

  function automatic logic snan_of(fp_t x);
    return nan_of(x) && !x.mantissa[22];
  endfunction

  function automatic logic zero_of(fp_t x);
    return (x.exponent == 8'd0) && (x.mantissa == 23'd0);
  endfunction

  // Unsigned key in numeric order, -0 just below +0
  function automatic logic [31:0] order_key(fp_t x);
    logic [31:0] bits;
    bits = x;
    return bits[31] ? ~bits : {1'b1, bits[30:0]};
  endfunction

  function automatic logic [9:0] class_of(fp_t x);
    logic [3:0] idx;
    if (nan_of(x)) idx = x.mantissa[22] ? 4'd9 : 4'd8;
    else if (x.exponent == 8'hff) idx = x.sign ? 4'd0 : 4'd7;
    else if (x.exponent != 8'd0) idx = x.sign ? 4'd1 : 4'd6;
    else if (x.mantissa != 23'd0) idx = x.sign ? 4'd2 : 4'd5;
    else idx = x.sign ? 4'd3 : 4'd4;
    return 10'd1 << idx;
  endfunction

  function automatic expect_t model(fp_t a, fp_t b, op_e op, mode_e mode, logic op_mod,
                                    logic [TAG_W-1:0] tag);
    expect_t e;
    logic    any_nan;
    logic    eq;
    logic    lt;
    e       = '0;
    e.tag   = tag;
    any_nan = nan_of(a) || nan_of(b);
    // Zeros of either sign are equal
    eq      = (a == b) || (zero_of(a) && zero_of(b));
    lt      = (order_key(a) < order_key(b)) && !eq;
    case (op)
      OP_SGNJ: begin
        e.result = a;
        if (mode == MODE_0) e.result.sign = b.sign;
        else if (mode == MODE_1) e.result.sign = ~b.sign;
        else if (mode == MODE_2) e.result.sign = a.sign ^ b.sign;
      end
      OP_MINMAX: begin
        if (mode == MODE_0 || mode == MODE_1) begin
          e.status.NV = snan_of(a) || snan_of(b);
          if (nan_of(a) && nan_of(b)) e.result = QNAN_BITS;
          else if (nan_of(a)) e.result = b;
          else if (nan_of(b)) e.result = a;
          else if ((order_key(a) < order_key(b)) == (mode == MODE_0)) e.result = a;
          else e.result = b;
        end
      end
      OP_CMP: begin
        // LE and LT give 0 on NaN, EQ inverts its NaN answer too
        if (mode == MODE_0 || mode == MODE_1) begin
          e.status.NV = any_nan;
          e.result[0] = !any_nan && (((mode == MODE_0) ? (lt || eq) : lt) ^ op_mod);
        end else if (mode == MODE_2) begin
          e.status.NV = snan_of(a) || snan_of(b);
          e.result[0] = (eq && !any_nan) ^ op_mod;
        end
      end
      default: begin
        e.mask     = class_of(a);
        e.is_class = 1'b1;
      end
    endcase
    return e;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  function automatic fp_t special_value(logic [3:0] sel);
    case (sel)
      4'd0:    return 32'h0000_0000;
      4'd1:    return 32'h8000_0000;
      4'd2:    return 32'h7f80_0000;
      4'd3:    return 32'hff80_0000;
      4'd4:    return 32'h7f80_0001;
      4'd5:    return 32'hffa0_0000;
      4'd6:    return 32'h7fc0_0000;
      4'd7:    return 32'hffc0_0123;
      4'd8:    return 32'h0000_0001;
      4'd9:    return 32'h807f_ffff;
      4'd10:   return 32'h3f80_0000;
      4'd11:   return 32'hbf80_0000;
      4'd12:   return 32'h7f7f_ffff;
      4'd13:   return 32'h0080_0000;
      4'd14:   return 32'hc020_0000;
      default: return 32'h0040_0000;
    endcase
  endfunction

  task automatic drive_new_item();
    logic [31:0] rnd;
    rnd         = $urandom;
    // One operand in four comes from the special table
    operand_a_i = (rnd[1:0] == 2'd0) ? special_value(rnd[7:4]) : fp_t'($urandom);
    operand_b_i = (rnd[3:2] == 2'd0) ? special_value(rnd[11:8]) : fp_t'($urandom);
    // Equal pairs hit the tie paths
    if (rnd[14:12] == 3'd0) begin
      operand_b_i = operand_a_i;
    end else if (rnd[14:12] == 3'd1) begin
      // Opposite-signed zeros reach the signed-zero ordering
      operand_a_i = {rnd[15], 31'd0};
      operand_b_i = {~rnd[15], 31'd0};
    end else if (rnd[14:12] == 3'd2) begin
      // Two table NaNs reach the canonical NaN result
      operand_a_i = special_value({2'b01, rnd[5:4]});
      operand_b_i = special_value({2'b01, rnd[9:8]});
    end
    op_i        = op_e'(rnd[17:16]);
    mode_i      = mode_e'(rnd[19:18]);
    op_mod_i    = rnd[20];
    tag_i       = rnd[27:24];
  endtask

  task automatic check_output();
    expect_t e;
    if (exp_q.size() == 0) begin
      $display("ERROR: an output appeared at %0t with no item outstanding", $time);
      errors++;
      return;
    end
    e = exp_q.pop_front();
    checked++;
    if (tag_o != e.tag) begin
      $display("FAIL @%0t: tag %h, expected %h", $time, tag_o, e.tag);
      errors++;
    end
    if (result_o != e.result) begin
      $display("FAIL @%0t: tag %h result %h, expected %h", $time, e.tag, result_o, e.result);
      errors++;
    end
    if (status_o != e.status) begin
      $display("FAIL @%0t: tag %h status %b, expected %b", $time, e.tag, status_o, e.status);
      errors++;
    end
    if (is_class_o != e.is_class) begin
      $display("FAIL @%0t: tag %h is_class %b, expected %b", $time, e.tag, is_class_o,
               e.is_class);
      errors++;
    end
    if (e.is_class && (class_mask_o != e.mask)) begin
      $display("FAIL @%0t: tag %h class mask %b, expected %b", $time, e.tag, class_mask_o,
               e.mask);
      errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard, sampled mid-cycle where all signals are settled
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (!reset_checked && (out_valid_o || busy_o || !in_ready_o)) begin
        $display("FAIL @%0t: state after reset valid %b busy %b ready %b", $time,
                 out_valid_o, busy_o, in_ready_o);
        errors++;
      end
      reset_checked = 1'b1;
      if (busy_check && busy_o) begin
        $display("FAIL @%0t: busy_o high on the cycle after a flush", $time);
        errors++;
      end
      busy_check = flush_i;
      if (flush_i) begin
        // Everything in flight is dropped at this edge
        exp_q.delete();
        in_fire = 1'b0;
      end else begin
        if (out_valid_o && out_ready_i) check_output();
        in_fire = in_valid_i && in_ready_o;
        if (in_fire) begin
          exp_q.push_back(model(operand_a_i, operand_b_i, op_i, mode_i, op_mod_i, tag_i));
          accepted++;
        end
      end
    end
  end

  // Main sequence
  initial begin
    logic [31:0] rnd;
    logic        hold;
    logic        done;
    int          leftover;
    void'($urandom(32'hfa65));
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b0;
    drive_new_item();
    done       = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      #1;
      // Payload stays put until taken, unless a flush dropped it
      hold        = in_valid_i && !in_fire && !flush_i;
      rnd         = $urandom;
      flush_i     = (rnd[5:0] == 6'd0);
      out_ready_i = !flush_i && (rnd[9:8] != 2'd0);
      if (!hold) begin
        if (accepted >= N_TXN) begin
          in_valid_i = 1'b0;
          done       = 1'b1;
        end else begin
          in_valid_i = (rnd[13:12] != 2'd0);
          if (in_valid_i) drive_new_item();
        end
      end
    end
    // Drain with the output always ready
    out_ready_i = 1'b1;
    flush_i     = 1'b0;
    @(negedge clk_i);
    while (busy_o) @(negedge clk_i);
    @(negedge clk_i);
    leftover = exp_q.size();
    if (leftover != 0) begin
      $display("ERROR: %0d accepted items never came out", leftover);
    end
    $display("errors: %0d, items checked: %0d, accepted: %0d", errors + leftover, checked,
             accepted);
    if (errors + leftover == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: run timed out after %0d ns without finishing", TIMEOUT_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* sim.f */
rtl/fpnc_pkg.sv
rtl/fpnc_classifier.sv
rtl/fpnc_pipe_stage.sv
rtl/fpnc_ops.sv
rtl/fpnc_top.sv
dv/fpnc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run into sim.log, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -j 0 --top-module fpnc_tb -f sim.f -o fpnc_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fpnc_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log && echo "Simulation passed" \
  || { echo "No result line found in sim.log"; exit 1; }
exit 0
